/* logic/cp0Pkg.sv */
package cp0Pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] wordT;     // Data word, PC and EPC
    typedef logic [4:0]  regAddrT;  // CP0 register number (rd field)
    typedef logic [4:0]  excCodeT;  // Cause.ExcCode

    // Number of external interrupt lines
    localparam int hwIntWidth = 6;

    ////////////////////////////////////////////////////////////////////////////
    // Register numbers
    ////////////////////////////////////////////////////////////////////////////

    localparam regAddrT regSr    = 5'd12;  // Status
    localparam regAddrT regCause = 5'd13;  // Cause
    localparam regAddrT regEpc   = 5'd14;  // Exception PC
    localparam regAddrT regPrid  = 5'd15;  // Processor ID, read only

    ////////////////////////////////////////////////////////////////////////////
    // Exception codes
    ////////////////////////////////////////////////////////////////////////////

    localparam excCodeT excInt  = 5'd0;   // Interrupt
    localparam excCodeT excAdEL = 5'd4;   // Address error on load or fetch
    localparam excCodeT excAdES = 5'd5;   // Address error on store
    localparam excCodeT excRi   = 5'd10;  // Reserved instruction
    localparam excCodeT excOv   = 5'd12;  // Arithmetic overflow

    // Anything else on the pipeline code input means no exception

    // Default PRId word, overridable from the top level
    localparam wordT defaultPrid = 32'h0001_8000;

endpackage

/* logic/statusReg.sv */
`timescale 1ns/1ps

module statusReg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          write,       // Software mtc0 strobe
    input  cp0Pkg::wordT                  dataIn,
    input  logic                          setLevel,    // Exception or interrupt taken
    input  logic                          clearLevel,  // eret
    output cp0Pkg::wordT                  value,
    output logic [cp0Pkg::hwIntWidth-1:0] interruptMask,
    output logic                          interruptEnable,
    output logic                          exceptionLevel
);
    import cp0Pkg::*;

    // Implemented fields only
    logic [hwIntWidth-1:0] imReg;   // IM, bits 15:10
    logic                  exlReg;  // EXL, bit 1
    logic                  ieReg;   // IE, bit 0

    ////////////////////////////////////////////////////////////////////////////
    // Field update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            imReg  <= '0;
            exlReg <= 1'b0;
            ieReg  <= 1'b0;
        end else begin
            if (write) begin
                imReg <= dataIn[15:10];
                ieReg <= dataIn[0];
            end

            // Request beats eret, both beat the software write
            if (setLevel) begin
                exlReg <= 1'b1;
            end else if (clearLevel) begin
                exlReg <= 1'b0;
            end else if (write) begin
                exlReg <= dataIn[1];
            end
        end
    end

    // Unimplemented bits read as zero
    always_comb begin
        value        = '0;
        value[15:10] = imReg;
        value[1]     = exlReg;
        value[0]     = ieReg;
    end

    // Field taps for the arbiter
    assign interruptMask   = imReg;
    assign interruptEnable = ieReg;
    assign exceptionLevel  = exlReg;

endmodule

/* logic/causeReg.sv */
`timescale 1ns/1ps

module causeReg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          capture,      // Request level from the arbiter
    input  logic                          branchDelay,  // Faulting instr sits in a delay slot
    input  cp0Pkg::excCodeT               code,         // Code chosen by the arbiter
    input  logic [cp0Pkg::hwIntWidth-1:0] hwInt,
    output cp0Pkg::wordT                  value
);
    import cp0Pkg::*;

    logic                  bdReg;       // BD, bit 31
    logic [hwIntWidth-1:0] pendingReg;  // IP, bits 15:10
    excCodeT               codeReg;     // ExcCode, bits 6:2

    ////////////////////////////////////////////////////////////////////////////
    // Pending interrupt sampling
    ////////////////////////////////////////////////////////////////////////////

    // Free-running sample of the lines, one cycle behind
    always_ff @(posedge clk) begin
        if (reset) begin
            pendingReg <= '0;
        end else begin
            pendingReg <= hwInt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Exception record
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bdReg   <= 1'b0;
            codeReg <= '0;
        end else if (capture) begin
            bdReg   <= branchDelay;  // Held until the next request
            codeReg <= code;
        end
    end

    // Pack into the architectural layout
    always_comb begin
        value        = '0;
        value[31]    = bdReg;
        value[15:10] = pendingReg;
        value[6:2]   = codeReg;
    end

    // Cause has no software write port
    // BD and ExcCode only move on a request
    // IP always reflects the lines from the previous cycle

endmodule

/* logic/epcReg.sv */
`timescale 1ns/1ps

module epcReg (
    input  logic         clk,
    input  logic         reset,
    input  logic         capture,  // Request level, loads pc
    input  cp0Pkg::wordT pc,       // PC of the faulting instruction
    input  logic         write,    // Software mtc0 strobe
    input  cp0Pkg::wordT dataIn,
    output cp0Pkg::wordT value
);
    import cp0Pkg::*;

    // Word address only, low two bits are always zero
    logic [29:0] addrReg;

    ////////////////////////////////////////////////////////////////////////////
    // Load
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            addrReg <= '0;
        end else if (capture) begin
            addrReg <= pc[31:2];      // Hardware capture wins
        end else if (write) begin
            addrReg <= dataIn[31:2];
        end
    end

    // Aligned return address
    wordT alignedValue;

    assign alignedValue = {addrReg, 2'b00};
    assign value        = alignedValue;

endmodule

/* logic/exceptionArbiter.sv */
`timescale 1ns/1ps

module exceptionArbiter (
    input  logic [cp0Pkg::hwIntWidth-1:0] hwInt,
    input  logic [cp0Pkg::hwIntWidth-1:0] interruptMask,
    input  logic                          interruptEnable,
    input  logic                          exceptionLevel,
    input  cp0Pkg::excCodeT               excCode,     // From the pipeline
    output logic                          request,     // Take interrupt or exception now
    output cp0Pkg::excCodeT               recordCode   // Code written into Cause
);
    import cp0Pkg::*;

    logic intPending;
    logic excPresent;

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt qualification
    ////////////////////////////////////////////////////////////////////////////

    // Any unmasked line, globally enabled, not already in a handler
    assign intPending = (|(hwInt & interruptMask)) && interruptEnable && !exceptionLevel;

    ////////////////////////////////////////////////////////////////////////////
    // Exception decode
    ////////////////////////////////////////////////////////////////////////////

    // Only four codes are real, everything else means idle
    always_comb begin
        case (excCode)
            excAdEL,
            excAdES,
            excRi,
            excOv:   excPresent = 1'b1;
            default: excPresent = 1'b0;
        endcase
    end

    // Synchronous exceptions ignore EXL
    assign request = intPending || excPresent;

    // Interrupt takes the recorded code
    always_comb begin
        if (intPending) begin
            recordCode = excInt;
        end else begin
            recordCode = excCode;  // Only meaningful when request is high
        end
    end

endmodule

/* logic/cp0.sv */
`timescale 1ns/1ps

module cp0 #(
    parameter cp0Pkg::wordT prid = cp0Pkg::defaultPrid
) (
    input  logic                          clk,
    input  logic                          reset,
    input  cp0Pkg::regAddrT               addrRead,     // mfc0 register number
    input  cp0Pkg::regAddrT               addrWrite,    // mtc0 register number
    input  cp0Pkg::wordT                  dataIn,       // mtc0 data
    input  logic                          writeEnable,
    input  cp0Pkg::wordT                  pc,
    input  logic                          branchDelay,
    input  cp0Pkg::excCodeT               excCode,
    input  logic [cp0Pkg::hwIntWidth-1:0] hwInt,
    input  logic                          eret,
    output logic                          intExcReq,
    output cp0Pkg::wordT                  epc,          // Return address for eret
    output cp0Pkg::wordT                  dataOut       // mfc0 data
);
    import cp0Pkg::*;

    logic                  srWrite;
    logic                  epcWrite;
    wordT                  srValue;
    wordT                  causeValue;
    wordT                  epcValue;
    wordT                  srWriteData;   // Software Status data, implemented fields only
    wordT                  epcWriteData;  // Aligned software EPC data
    logic [hwIntWidth-1:0] interruptMask;
    logic                  interruptEnable;
    logic                  exceptionLevel;
    excCodeT               recordCode;

    ////////////////////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////////////////////

    // Cause and PRId writes fall through and are dropped
    assign srWrite  = writeEnable && (addrWrite == regSr);
    assign epcWrite = writeEnable && (addrWrite == regEpc);

    // IM, EXL and IE survive, the rest reads as zero
    always_comb begin
        srWriteData        = '0;
        srWriteData[15:10] = dataIn[15:10];
        srWriteData[1:0]   = dataIn[1:0];
    end

    assign epcWriteData = {dataIn[31:2], 2'b00};

    ////////////////////////////////////////////////////////////////////////////
    // Read mux with same-cycle bypass
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (addrRead)
            regSr:    dataOut = srWrite ? srWriteData : srValue;     // Masked write data forwarded
            regCause: dataOut = causeValue;
            regEpc:   dataOut = epcWrite ? epcWriteData : epcValue;
            regPrid:  dataOut = prid;
            default:  dataOut = '0;                                  // Unmapped
        endcase
    end

    // Return address seen by the fetch stage
    assign epc = epcWrite ? epcWriteData : epcValue;

    ////////////////////////////////////////////////////////////////////////////
    // Registers and arbitration
    ////////////////////////////////////////////////////////////////////////////

    statusReg statusReg0 (
        .clk             (clk),
        .reset           (reset),
        .write           (srWrite),
        .dataIn          (dataIn),
        .setLevel        (intExcReq),  // Entering a handler
        .clearLevel      (eret),
        .value           (srValue),
        .interruptMask   (interruptMask),
        .interruptEnable (interruptEnable),
        .exceptionLevel  (exceptionLevel)
    );

    causeReg causeReg0 (
        .clk         (clk),
        .reset       (reset),
        .capture     (intExcReq),
        .branchDelay (branchDelay),
        .code        (recordCode),
        .hwInt       (hwInt),
        .value       (causeValue)
    );

    epcReg epcReg0 (
        .clk     (clk),
        .reset   (reset),
        .capture (intExcReq),
        .pc      (pc),
        .write   (epcWrite),
        .dataIn  (dataIn),
        .value   (epcValue)
    );

    exceptionArbiter exceptionArbiter0 (
        .hwInt           (hwInt),
        .interruptMask   (interruptMask),
        .interruptEnable (interruptEnable),
        .exceptionLevel  (exceptionLevel),
        .excCode         (excCode),
        .request         (intExcReq),
        .recordCode      (recordCode)
    );

endmodule

/* verification/cp0Tb.sv */
`timescale 1ns/1ps

module cp0Tb;
    import cp0Pkg::*;

    localparam int randomCycles = 3000;
    localparam int resetTimeout = 50;  // Cycles allowed for reset release

    logic                  clk;
    logic                  reset;
    regAddrT               addrRead;
    regAddrT               addrWrite;
    wordT                  dataIn;
    logic                  writeEnable;
    wordT                  pc;
    logic                  branchDelay;
    excCodeT               excCode;
    logic [hwIntWidth-1:0] hwInt;
    logic                  eret;
    logic                  intExcReq;
    wordT                  epc;
    wordT                  dataOut;

    wordT rngState;

    // Reference state of the CP0 registers
    logic [hwIntWidth-1:0] modelIm;
    logic                  modelExl;
    logic                  modelIe;
    logic                  modelBd;
    logic [hwIntWidth-1:0] modelPending;
    excCodeT               modelCode;
    wordT                  modelEpc;

    cp0 dut0 (
        .clk         (clk),
        .reset       (reset),
        .addrRead    (addrRead),
        .addrWrite   (addrWrite),
        .dataIn      (dataIn),
        .writeEnable (writeEnable),
        .pc          (pc),
        .branchDelay (branchDelay),
        .excCode     (excCode),
        .hwInt       (hwInt),
        .eret        (eret),
        .intExcReq   (intExcReq),
        .epc         (epc),
        .dataOut     (dataOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random source and compare helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic wordT xorshift32(input wordT s);
        wordT x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output wordT r);
        rngState = xorshift32(rngState);
        r        = rngState;
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("Fail at %0t ps: %s expected %h actual %h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Word mismatch on %s", name);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t ps: %s expected %b actual %b", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Flag mismatch on %s", name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One clock cycle of stimulus, check and model update
    ////////////////////////////////////////////////////////////////////////////

    task automatic runCycle(input regAddrT rdAddr, input regAddrT wrAddr, input wordT wrData,
                            input logic wrEn, input wordT pcIn, input logic bdIn,
                            input excCodeT codeIn, input logic [hwIntWidth-1:0] intIn,
                            input logic eretIn);
        logic intPend;
        logic excValid;
        logic expReq;
        logic srWr;
        logic epcWr;
        wordT statusWord;
        wordT causeWord;
        wordT srData;
        wordT alignedData;
        wordT expData;
        wordT expEpc;
        @(posedge clk);
        #1;
        addrRead    = rdAddr;
        addrWrite   = wrAddr;
        dataIn      = wrData;
        writeEnable = wrEn;
        pc          = pcIn;
        branchDelay = bdIn;
        excCode     = codeIn;
        hwInt       = intIn;
        eret        = eretIn;

        intPend  = (|(intIn & modelIm)) && modelIe && !modelExl;
        excValid = (codeIn == excAdEL) || (codeIn == excAdES) || (codeIn == excRi)
                   || (codeIn == excOv);
        expReq   = intPend || excValid;
        srWr     = wrEn && (wrAddr == regSr);
        epcWr    = wrEn && (wrAddr == regEpc);

        statusWord  = {16'h0, modelIm, 8'h0, modelExl, modelIe};
        causeWord   = {modelBd, 15'h0, modelPending, 3'b000, modelCode, 2'b00};
        srData      = {16'h0, wrData[15:10], 8'h0, wrData[1:0]};  // Only IM, EXL, IE
        alignedData = {wrData[31:2], 2'b00};
        expEpc      = epcWr ? alignedData : modelEpc;  // Bypassed return address

        case (rdAddr)
            regSr:    expData = srWr ? srData : statusWord;
            regCause: expData = causeWord;
            regEpc:   expData = expEpc;
            regPrid:  expData = defaultPrid;
            default:  expData = '0;
        endcase

        #17;  // 2 ns before the next edge
        checkFlag("intExcReq", expReq, intExcReq);
        checkWord("dataOut", expData, dataOut);
        checkWord("epc", expEpc, epc);

        // Next state
        if (srWr) begin
            modelIm = wrData[15:10];
            modelIe = wrData[0];
        end
        if (expReq) begin
            modelExl = 1'b1;
        end else if (eretIn) begin
            modelExl = 1'b0;
        end else if (srWr) begin
            modelExl = wrData[1];
        end
        modelPending = intIn;  // IP lags one cycle
        if (expReq) begin
            modelBd   = bdIn;
            modelCode = intPend ? excInt : codeIn;
            modelEpc  = {pcIn[31:2], 2'b00};
        end else if (epcWr) begin
            modelEpc = alignedData;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        wordT    r0;
        wordT    r1;
        wordT    r2;
        wordT    r3;
        regAddrT rdAddr;
        regAddrT wrAddr;
        excCodeT codeIn;
        int      cycles;
        reset        = 1'b1;
        addrRead     = '0;
        addrWrite    = '0;
        dataIn       = '0;
        writeEnable  = 1'b0;
        pc           = '0;
        branchDelay  = 1'b0;
        excCode      = excInt;
        hwInt        = '0;
        eret         = 1'b0;
        rngState     = 32'hc3605068;
        modelIm      = '0;
        modelExl     = 1'b0;
        modelIe      = 1'b0;
        modelBd      = 1'b0;
        modelPending = '0;
        modelCode    = excInt;
        modelEpc     = '0;

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;

        cycles = 0;
        while (reset !== 1'b0) begin
            if (cycles >= resetTimeout) begin
                $display("Timed out waiting for reset to be released");
                $display("Simulation failed");
                $fatal(1, "Reset wait timeout");
            end
            @(posedge clk);
            cycles++;
        end

        // Reset values and an unmapped number
        runCycle(regSr, 5'd0, '0, 1'b0, '0, 1'b0, excInt, '0, 1'b0);
        runCycle(regCause, 5'd0, '0, 1'b0, '0, 1'b0, excInt, '0, 1'b0);
        runCycle(regEpc, 5'd0, '0, 1'b0, '0, 1'b0, excInt, '0, 1'b0);
        runCycle(5'd3, 5'd0, '0, 1'b0, '0, 1'b0, excInt, '0, 1'b0);
        // Status bypass then masked readback
        runCycle(regSr, regSr, 32'hFFFF_FFFF, 1'b1, '0, 1'b0, excInt, '0, 1'b0);
        runCycle(regSr, regSr, 32'h0000_FC01, 1'b1, '0, 1'b0, excInt, '0, 1'b0);
        // EPC alignment, then capture over a write
        runCycle(regEpc, regEpc, 32'h1234_5677, 1'b1, '0, 1'b0, excInt, '0, 1'b0);
        runCycle(regEpc, regEpc, 32'h5555_5555, 1'b1, 32'h0000_4003, 1'b1, excOv, '0, 1'b0);
        runCycle(regCause, 5'd0, '0, 1'b0, '0, 1'b0, excRi, 6'b000100, 1'b0);  // EXL set
        runCycle(regCause, 5'd0, '0, 1'b0, '0, 1'b0, 5'd1, 6'b000100, 1'b1);   // eret
        runCycle(regCause, 5'd0, '0, 1'b0, 32'h0000_0800, 1'b0, excInt, 6'b000100, 1'b0);
        // PRId and dropped writes
        runCycle(regPrid, regCause, 32'hFFFF_FFFF, 1'b1, '0, 1'b0, excInt, '0, 1'b0);
        runCycle(regCause, regPrid, 32'hDEAD_BEEF, 1'b1, '0, 1'b0, excInt, '0, 1'b0);

        for (int i = 0; i < randomCycles; i++) begin
            drawRandom(r0);
            drawRandom(r1);
            drawRandom(r2);
            drawRandom(r3);
            rdAddr = (r0[2:0] < 3'd6) ? {3'b011, r0[4:3]} : r0[9:5];     // Mostly 12 to 15
            wrAddr = (r0[12:10] < 3'd6) ? {3'b011, r0[14:13]} : r0[19:15];
            case (r0[23:20])
                4'd0:    codeIn = excAdEL;
                4'd1:    codeIn = excAdES;
                4'd2:    codeIn = excRi;
                4'd3:    codeIn = excOv;
                4'd4:    codeIn = 5'd1;   // Invalid code
                4'd5:    codeIn = 5'd31;
                default: codeIn = excInt; // Idle pipeline
            endcase
            runCycle(rdAddr, wrAddr, r1, r3[14] & r3[15], r2, r0[26], codeIn,
                     r3[5:0] & r3[11:6], r3[12] & r3[13]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* tb.f */
logic/cp0Pkg.sv
logic/statusReg.sv
logic/causeReg.sv
logic/epcReg.sv
logic/exceptionArbiter.sv
logic/cp0.sv
verification/cp0Tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CP0 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module cp0Tb -f tb.f --Mdir obj_dir -o cp0TbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/cp0TbSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
